/* verilog/upd_periph_consts.svh */
// Reset values, interrupt vector addresses, sample divider and timer prescaler constants
`ifndef UPD_PERIPH_CONSTS_SVH
`define UPD_PERIPH_CONSTS_SVH

//////////////////////////////
// Register reset values

// Port latches come up low
`define PORT_RST 8'h00

// MB, MC and MK come up all ones: ports as inputs, interrupts masked
`define MODE_RST 8'hFF

// Timer reload value, 12 bits
`define TM_RST 12'hFFF

//////////////////////////////
// Dividers

// INT1/INT2 sample enable, once every this many cycles
`define DIV_SAMPLE 12

// Prescaler below the 12-bit timer count
`define TM_PRESCALE_BITS 3

//////////////////////////////
// Interrupt vector addresses

`define VEC_INT0 8'h04
`define VEC_INTT 8'h08
`define VEC_INT1 8'h10
`define VEC_INT2 8'h20

`endif

/* verilog/upd_periph_pkg.sv */
// Package with data widths, special register select, interrupt index and register write types
package upd_periph_pkg;

  //////////////////////////////
  // Widths

  // One data byte on the register bus
  typedef logic [7:0] byte_t;

  // Timer reload value from TM1[3:0] and TM0
  typedef logic [11:0] tm_count_t;

  // One flag per interrupt source, indexed by int_idx_e
  typedef logic [3:0] int_vec_t;

  //////////////////////////////
  // Encodings

  // Special register numbers as used by the MOV sr instructions
  typedef enum logic [3:0] {
    SPR_PA  = 4'h0,
    SPR_PB  = 4'h1,
    SPR_PC  = 4'h2,
    SPR_MK  = 4'h3,
    SPR_MB  = 4'h4,
    SPR_MC  = 4'h5,
    SPR_TM0 = 4'h6,
    SPR_TM1 = 4'h7
  } spr_sel_e;

  // Interrupt positions, also the fixed priority order (0 highest)
  typedef enum logic [1:0] {
    IDX_INT0 = 2'd0,
    IDX_INTT = 2'd1,
    IDX_INT1 = 2'd2,
    IDX_INT2 = 2'd3
  } int_idx_e;

  // One special register write, takes effect at the next edge
  typedef struct packed {
    logic     valid;
    spr_sel_e sel;
    byte_t    data;
  } spr_wr_t;

endpackage

/* verilog/port_block.sv */
// Port A/B/C latches, MB/MC mode registers, output enables and port read-back
`timescale 1ns/1ps
`include "upd_periph_consts.svh"

module port_block (
  input  logic                    CLK,
  input  logic                    rst,
  input  upd_periph_pkg::spr_wr_t spr_wr,
  input  upd_periph_pkg::byte_t   pb_in,
  input  upd_periph_pkg::byte_t   pc_in,
  output upd_periph_pkg::byte_t   pa_out,
  output upd_periph_pkg::byte_t   pb_out,
  output upd_periph_pkg::byte_t   pb_oe,
  output upd_periph_pkg::byte_t   pc_out,
  output upd_periph_pkg::byte_t   pc_oe,
  output upd_periph_pkg::byte_t   pb_read,
  output upd_periph_pkg::byte_t   pc_read,
  output upd_periph_pkg::byte_t   mb,
  output upd_periph_pkg::byte_t   mc
);
  import upd_periph_pkg::*;

  // Port C bits 6..2 have fixed directions, only bits 4..2 drive
  localparam logic [4:0] PC_OE_FIXED = 5'b00111;

  //////////////////////////////
  // Latches and mode registers

  always_ff @(posedge CLK) begin
    if (rst) begin
      pa_out <= `PORT_RST;
      pb_out <= `PORT_RST;
      pc_out <= `PORT_RST;
      mb     <= `MODE_RST;
      mc     <= `MODE_RST;
    end else if (spr_wr.valid) begin
      case (spr_wr.sel)
        SPR_PA:  pa_out <= spr_wr.data;
        SPR_PB:  pb_out <= spr_wr.data;
        SPR_PC:  pc_out <= spr_wr.data;
        SPR_MB:  mb     <= spr_wr.data;
        SPR_MC:  mc     <= spr_wr.data;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Directions

  // A set mode bit makes the pin an input
  assign pb_oe = ~mb;
  assign pc_oe = {~mc[7], PC_OE_FIXED, ~mc[1:0]};

  // Read-back takes the pin on inputs and the latch on outputs
  assign pb_read = (pb_in & ~pb_oe) | (pb_out & pb_oe);
  assign pc_read = (pc_in & ~pc_oe) | (pc_out & pc_oe);

endmodule

/* verilog/interval_timer.sv */
// Interval timer with TM0/TM1 reload registers, prescaled down counter and underflow strobe
`timescale 1ns/1ps
`include "upd_periph_consts.svh"

module interval_timer (
  input  logic                      CLK,
  input  logic                      rst,
  input  upd_periph_pkg::spr_wr_t   spr_wr,
  input  logic                      timer_start,
  output upd_periph_pkg::tm_count_t tm_reload,
  output logic                      tm_uf
);
  import upd_periph_pkg::*;

  // Reload count with the prescaler in the low bits
  localparam int CNT_W = $bits(tm_count_t) + `TM_PRESCALE_BITS;

  logic [CNT_W-1:0] tm_cnt;

  //////////////////////////////
  // Reload registers

  // TM0 is the low byte, TM1 carries the top nibble
  always_ff @(posedge CLK) begin
    if (rst) begin
      tm_reload <= `TM_RST;
    end else if (spr_wr.valid) begin
      case (spr_wr.sel)
        SPR_TM0: tm_reload[7:0]  <= spr_wr.data;
        SPR_TM1: tm_reload[11:8] <= spr_wr.data[3:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Down counter

  // Underflow on the cycle the whole count reads zero
  assign tm_uf = (tm_cnt == '0);

  // Reload resets the prescaler to all ones, so one period is
  // (reload + 1) * 8 cycles
  always_ff @(posedge CLK) begin
    if (rst) begin
      tm_cnt <= '1;
    end else if (tm_uf || timer_start) begin
      tm_cnt <= {tm_reload, {`TM_PRESCALE_BITS{1'b1}}};
    end else begin
      tm_cnt <= tm_cnt - 1'b1;
    end
  end

endmodule

/* verilog/int_controller.sv */
// Interrupt controller with sample divider, INT1/INT2 filters, pending flags, mask and priority vector
`timescale 1ns/1ps
`include "upd_periph_consts.svh"

module int_controller (
  input  logic                    CLK,
  input  logic                    rst,
  input  upd_periph_pkg::spr_wr_t spr_wr,
  input  logic                    int0,
  input  logic                    int1,
  input  logic                    int2,
  input  logic                    tm_uf,
  input  logic                    int_enable,
  input  logic                    int_ack,
  output upd_periph_pkg::byte_t   mk,
  output logic                    int_req,
  output upd_periph_pkg::byte_t   int_vector
);
  import upd_periph_pkg::*;

  logic [3:0] div_cnt;
  logic       sample_en;
  logic       int2_pol;
  logic [3:0] filt1;
  logic [3:0] filt2;
  int_vec_t   pend;
  int_vec_t   pend_set;
  int_vec_t   pend_clr;
  int_vec_t   pend_lat;
  int_vec_t   enable_mask;
  int_vec_t   ack_sel;

  //////////////////////////////
  // Mask register

  always_ff @(posedge CLK) begin
    if (rst) begin
      mk <= `MODE_RST;
    end else if (spr_wr.valid && (spr_wr.sel == SPR_MK)) begin
      mk <= spr_wr.data;
    end
  end

  //////////////////////////////
  // INT1/INT2 sampling

  assign sample_en = (div_cnt == 4'(`DIV_SAMPLE - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= sample_en ? 4'd0 : div_cnt + 4'd1;
    end
  end

  // MK bit 5 clear turns INT2 into an active-low input
  assign int2_pol = int2 ^ ~mk[5];

  always_ff @(posedge CLK) begin
    if (rst) begin
      filt1 <= '0;
      filt2 <= '0;
    end else if (sample_en) begin
      filt1 <= {filt1[2:0], int1};
      filt2 <= {filt2[2:0], int2_pol};
    end
  end

  //////////////////////////////
  // Pending flags

  // Filtered sources fire on the sample that completes low, high, high, high
  always_comb begin
    pend_set = '0;
    pend_set[IDX_INT0] = int0;
    pend_set[IDX_INTT] = tm_uf;
    pend_set[IDX_INT1] = sample_en && ({filt1[2:0], int1} == 4'b0111);
    pend_set[IDX_INT2] = sample_en && ({filt2[2:0], int2_pol} == 4'b0111);
  end

  // INT0 is a level, so its flag also drops with the pin
  always_comb begin
    pend_clr = ack_sel & {4{int_ack}};
    pend_clr[IDX_INT0] = pend_clr[IDX_INT0] | ~int0;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  //////////////////////////////
  // Request latch

  // MK bits 3..0 line up with the source index
  assign enable_mask = {4{int_enable}} & ~mk[3:0];

  // Holds steady from request until acknowledge
  always_ff @(posedge CLK) begin
    if (rst) begin
      pend_lat <= '0;
    end else if (int_ack) begin
      pend_lat <= '0;
    end else if (pend_lat == '0) begin
      pend_lat <= pend & enable_mask;
    end
  end

  assign int_req = |pend_lat;

  //////////////////////////////
  // Priority and vector

  always_comb begin
    casez (pend_lat)
      4'b???1: ack_sel = 4'b0001;
      4'b??10: ack_sel = 4'b0010;
      4'b?100: ack_sel = 4'b0100;
      4'b1000: ack_sel = 4'b1000;
      default: ack_sel = 4'b0000;
    endcase
  end

  always_comb begin
    case (1'b1)
      ack_sel[IDX_INT0]: int_vector = `VEC_INT0;
      ack_sel[IDX_INTT]: int_vector = `VEC_INTT;
      ack_sel[IDX_INT1]: int_vector = `VEC_INT1;
      ack_sel[IDX_INT2]: int_vector = `VEC_INT2;
      default:           int_vector = 8'h00;
    endcase
  end

endmodule

/* verilog/upd_periph_top.sv */
// Peripheral top level with special register read multiplexer, ports, timer and interrupt controller
`timescale 1ns/1ps

module upd_periph_top (
  input  logic                     CLK,
  input  logic                     rst,
  input  upd_periph_pkg::spr_wr_t  spr_wr,
  input  upd_periph_pkg::spr_sel_e rd_sel,
  output upd_periph_pkg::byte_t    rd_data,
  input  upd_periph_pkg::byte_t    pb_in,
  input  upd_periph_pkg::byte_t    pc_in,
  output upd_periph_pkg::byte_t    pa_out,
  output upd_periph_pkg::byte_t    pb_out,
  output upd_periph_pkg::byte_t    pb_oe,
  output upd_periph_pkg::byte_t    pc_out,
  output upd_periph_pkg::byte_t    pc_oe,
  input  logic                     int0,
  input  logic                     int1,
  input  logic                     int2,
  input  logic                     int_enable,
  input  logic                     int_ack,
  input  logic                     timer_start,
  output logic                     int_req,
  output upd_periph_pkg::byte_t    int_vector
);
  import upd_periph_pkg::*;

  byte_t     pb_read;
  byte_t     pc_read;
  byte_t     mb;
  byte_t     mc;
  byte_t     mk;
  tm_count_t tm_reload;
  logic      tm_uf;

  //////////////////////////////
  // Blocks

  port_block u_ports (
    .CLK     (CLK),
    .rst     (rst),
    .spr_wr  (spr_wr),
    .pb_in   (pb_in),
    .pc_in   (pc_in),
    .pa_out  (pa_out),
    .pb_out  (pb_out),
    .pb_oe   (pb_oe),
    .pc_out  (pc_out),
    .pc_oe   (pc_oe),
    .pb_read (pb_read),
    .pc_read (pc_read),
    .mb      (mb),
    .mc      (mc)
  );

  interval_timer u_timer (
    .CLK         (CLK),
    .rst         (rst),
    .spr_wr      (spr_wr),
    .timer_start (timer_start),
    .tm_reload   (tm_reload),
    .tm_uf       (tm_uf)
  );

  int_controller u_intc (
    .CLK        (CLK),
    .rst        (rst),
    .spr_wr     (spr_wr),
    .int0       (int0),
    .int1       (int1),
    .int2       (int2),
    .tm_uf      (tm_uf),
    .int_enable (int_enable),
    .int_ack    (int_ack),
    .mk         (mk),
    .int_req    (int_req),
    .int_vector (int_vector)
  );

  //////////////////////////////
  // Register read-back

  always_comb begin
    case (rd_sel)
      SPR_PA:  rd_data = pa_out;
      SPR_PB:  rd_data = pb_read;
      SPR_PC:  rd_data = pc_read;
      SPR_MK:  rd_data = mk;
      SPR_MB:  rd_data = mb;
      SPR_MC:  rd_data = mc;
      SPR_TM0: rd_data = tm_reload[7:0];
      SPR_TM1: rd_data = {4'h0, tm_reload[11:8]};
      default: rd_data = 8'h00;
    endcase
  end

endmodule

/* test/tb_clock.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic rst
);

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Reset held for 8 rising edges, released just after the last one
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge CLK);
    #1 rst = 1'b0;
  end

endmodule

/* test/upd_periph_tb.sv */
// Directed testbench with port, timer, interrupt filter and priority tests, check task and timeout
`timescale 1ns/1ps

module upd_periph_tb;
  import upd_periph_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic     CLK;
  logic     rst;
  spr_wr_t  spr_wr;
  spr_sel_e rd_sel;
  byte_t    rd_data;
  byte_t    pb_in;
  byte_t    pc_in;
  byte_t    pa_out;
  byte_t    pb_out;
  byte_t    pb_oe;
  byte_t    pc_out;
  byte_t    pc_oe;
  logic     int0;
  logic     int1;
  logic     int2;
  logic     int_enable;
  logic     int_ack;
  logic     timer_start;
  logic     int_req;
  byte_t    int_vector;

  int cycle = 0;
  int checks = 0;
  int errors = 0;
  int seed_draw;

  tb_clock u_clock (
    .CLK (CLK),
    .rst (rst)
  );

  upd_periph_top u_upd_periph_top (
    .CLK         (CLK),
    .rst         (rst),
    .spr_wr      (spr_wr),
    .rd_sel      (rd_sel),
    .rd_data     (rd_data),
    .pb_in       (pb_in),
    .pc_in       (pc_in),
    .pa_out      (pa_out),
    .pb_out      (pb_out),
    .pb_oe       (pb_oe),
    .pc_out      (pc_out),
    .pc_oe       (pc_oe),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .int_enable  (int_enable),
    .int_ack     (int_ack),
    .timer_start (timer_start),
    .int_req     (int_req),
    .int_vector  (int_vector)
  );

  //////////////////////////////
  // Cycle count and timeout

  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // One register write taken at the following edge
  task automatic write_reg(input spr_sel_e sel, input byte_t data);
    @(posedge CLK);
    #1;
    spr_wr.valid = 1'b1;
    spr_wr.sel   = sel;
    spr_wr.data  = data;
    @(posedge CLK);
    #1;
    spr_wr.valid = 1'b0;
  endtask

  task automatic compare_read(input spr_sel_e sel, input byte_t exp, input string name);
    @(posedge CLK);
    #1;
    rd_sel = sel;
    @(negedge CLK);
    check_val(name, rd_data, exp);
  endtask

  // Watches int_req at falling edges for up to limit cycles
  task automatic wait_req(input int limit, output bit seen, output int at_cycle);
    int n;
    seen = 1'b0;
    at_cycle = 0;
    for (n = 0; n < limit && !seen; n++) begin
      @(negedge CLK);
      if (int_req) begin
        seen = 1'b1;
        at_cycle = cycle;
      end
    end
  endtask

  // One-cycle ack that also sets the new int_enable on the same edge
  task automatic acknowledge(input bit enable_after);
    @(posedge CLK);
    #1;
    int_ack = 1'b1;
    int_enable = enable_after;
    @(posedge CLK);
    #1;
    int_ack = 1'b0;
  endtask

  //////////////////////////////
  // Directed tests

  task automatic check_reset_values;
    @(negedge CLK);
    check_val("pb_oe", pb_oe, 8'h00);
    check_val("pc_oe", pc_oe, 8'h1C);
    check_val("int_req", int_req, 1'b0);
    check_val("pa_out", pa_out, 8'h00);
    compare_read(SPR_MK, 8'hFF, "rd_data MK");
    compare_read(SPR_MB, 8'hFF, "rd_data MB");
    compare_read(SPR_MC, 8'hFF, "rd_data MC");
    compare_read(SPR_TM0, 8'hFF, "rd_data TM0");
    compare_read(SPR_TM1, 8'h0F, "rd_data TM1");
    compare_read(SPR_PA, 8'h00, "rd_data PA");
  endtask

  task automatic exercise_ports;
    byte_t mb_v;
    byte_t mc_v;
    byte_t pa_v;
    byte_t pb_v;
    byte_t pc_v;
    byte_t in_c;
    byte_t exp_b;
    byte_t exp_c;
    byte_t exp_oe_b;
    byte_t exp_oe_c;
    int k;
    int i;
    for (k = 0; k < 4; k++) begin
      mb_v = $urandom;
      mc_v = $urandom;
      pa_v = $urandom;
      pb_v = $urandom;
      pc_v = $urandom;
      write_reg(SPR_MB, mb_v);
      write_reg(SPR_PB, pb_v);
      write_reg(SPR_MC, mc_v);
      write_reg(SPR_PC, pc_v);
      write_reg(SPR_PA, pa_v);
      pb_in = $urandom;
      pc_in = $urandom;
      // Port C inputs are bit 7 and bits 1..0 by MC plus bits 6 and 5 always
      in_c = {mc_v[7], 2'b11, 3'b000, mc_v[1:0]};
      exp_oe_b = ~mb_v;
      exp_oe_c = ~in_c;
      for (i = 0; i < 8; i++) begin
        exp_b[i] = mb_v[i] ? pb_in[i] : pb_v[i];
        exp_c[i] = in_c[i] ? pc_in[i] : pc_v[i];
      end
      @(negedge CLK);
      check_val("pb_oe", pb_oe, exp_oe_b);
      check_val("pc_oe", pc_oe, exp_oe_c);
      check_val("pa_out", pa_out, pa_v);
      check_val("pb_out", pb_out, pb_v);
      check_val("pc_out", pc_out, pc_v);
      compare_read(SPR_PB, exp_b, "rd_data PB");
      compare_read(SPR_PC, exp_c, "rd_data PC");
      compare_read(SPR_PA, pa_v, "rd_data PA");
      compare_read(SPR_MB, mb_v, "rd_data MB");
      compare_read(SPR_MC, mc_v, "rd_data MC");
    end
  endtask

  task automatic measure_timer;
    bit seen;
    int t0;
    int t1;
    int t2;
    write_reg(SPR_TM0, 8'h03);
    write_reg(SPR_TM1, 8'h00);
    compare_read(SPR_TM0, 8'h03, "rd_data TM0");
    compare_read(SPR_TM1, 8'h00, "rd_data TM1");
    // Only the timer source unmasked
    write_reg(SPR_MK, 8'hFD);
    compare_read(SPR_MK, 8'hFD, "rd_data MK");
    int_enable = 1'b1;
    @(posedge CLK);
    #1 timer_start = 1'b1;
    @(posedge CLK);
    #1 timer_start = 1'b0;
    wait_req(48, seen, t0);
    if (!seen) report_failure("Timer: no interrupt request after the start strobe");
    check_val("int_vector", int_vector, 8'h08);
    acknowledge(1'b1);
    wait_req(48, seen, t1);
    if (!seen) report_failure("Timer: first periodic request did not arrive");
    acknowledge(1'b1);
    wait_req(48, seen, t2);
    if (!seen) report_failure("Timer: second periodic request did not arrive");
    // Reload 3 gives (3 + 1) * 8 cycles
    check_val("underflow period", t2 - t1, 32);
    acknowledge(1'b0);
  endtask

  task automatic filter_int1_int2;
    bit seen;
    int t;
    // INT1 and INT2 unmasked with INT2 active high
    write_reg(SPR_MK, 8'hF3);
    int_enable = 1'b1;
    int1 = 1'b1;
    wait_cycles(10);
    int1 = 1'b0;
    wait_req(60, seen, t);
    if (seen) report_failure("INT1: a 10-cycle pulse raised an interrupt request");
    @(posedge CLK);
    #1 int1 = 1'b1;
    wait_req(40, seen, t);
    if (!seen) report_failure("INT1: held high gave no request within 40 cycles");
    check_val("int_vector", int_vector, 8'h10);
    acknowledge(1'b1);
    int1 = 1'b0;
    // With MK bit 5 clear the low INT2 pin counts as active
    write_reg(SPR_MK, 8'hD3);
    wait_req(40, seen, t);
    if (!seen) report_failure("INT2: held low gave no request within 40 cycles");
    check_val("int_vector", int_vector, 8'h20);
    acknowledge(1'b0);
    write_reg(SPR_MK, 8'hF3);
  endtask

  task automatic priority_and_masking;
    bit seen;
    int t;
    // INT0 and timer unmasked and the timer flag pending again by the end of the wait
    write_reg(SPR_MK, 8'hFC);
    int0 = 1'b1;
    wait_cycles(40);
    int_enable = 1'b1;
    wait_req(8, seen, t);
    if (!seen) report_failure("Priority: no request with INT0 and timer pending");
    check_val("int_vector", int_vector, 8'h04);
    @(posedge CLK);
    #1 int0 = 1'b0;
    acknowledge(1'b1);
    wait_req(48, seen, t);
    if (!seen) report_failure("Priority: timer request missing after INT0 was served");
    check_val("int_vector", int_vector, 8'h08);
    acknowledge(1'b0);

    // INT0 masked by MK bit 0
    write_reg(SPR_MK, 8'hF3);
    int0 = 1'b1;
    int_enable = 1'b1;
    wait_req(20, seen, t);
    if (seen) report_failure("Masking: INT0 raised a request with MK bit 0 set");

    // Everything unmasked but the global enable is low
    @(posedge CLK);
    #1 int_enable = 1'b0;
    write_reg(SPR_MK, 8'h00);
    wait_req(40, seen, t);
    if (seen) report_failure("Masking: a request was raised with int_enable low");
    @(posedge CLK);
    #1 int0 = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    spr_wr      = '0;
    rd_sel      = SPR_PA;
    pb_in       = 8'h00;
    pc_in       = 8'h00;
    int0        = 1'b0;
    int1        = 1'b0;
    int2        = 1'b0;
    int_enable  = 1'b0;
    int_ack     = 1'b0;
    timer_start = 1'b0;
    seed_draw   = $urandom(64381);

    wait (rst === 1'b0);
    @(posedge CLK);
    #1;

    check_reset_values();
    exercise_ports();
    measure_timer();
    filter_int1_int2();
    priority_and_masking();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+verilog
verilog/upd_periph_pkg.sv
verilog/port_block.sv
verilog/interval_timer.sv
verilog/int_controller.sv
verilog/upd_periph_top.sv
test/tb_clock.sv
test/upd_periph_tb.sv

/* Bender.yml */
package:
  name: upd_periph

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/upd_periph_pkg.sv
      - verilog/port_block.sv
      - verilog/interval_timer.sv
      - verilog/int_controller.sv
      - verilog/upd_periph_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/upd_periph_tb.sv
